/* arm_pkg.sv */
// ARM core shared definitions
package arm_pkg;

	// Program counter after reset
	localparam logic [31:0] start_address = 32'h0;

	// Register numbers with a fixed role
	localparam logic [3:0] reg_pc = 4'd15;
	localparam logic [3:0] reg_lr = 4'd14;

	// Instruction families of the supported subset
	typedef enum logic [2:0] {
		fam_dpi,    // Data processing, rotated immediate
		fam_dpis,   // Data processing, immediate shift
		fam_dprs,   // Data processing, register shift
		fam_lsio,   // Word load/store, immediate offset
		fam_branch, // B and BL
		fam_undef   // Outside the subset, runs as a no-op
	} family_e;

	// Controller states
	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_exec,
		st_mem_addr,
		st_mem_read,
		st_writeback,
		st_mem_write
	} state_e;

	// ALU opcodes in ARM encoding order (ir[24:21])
	typedef enum logic [3:0] {
		op_and, op_eor, op_sub, op_rsb,
		op_add, op_adc, op_sbc, op_rsc,
		op_tst, op_teq, op_cmp, op_cmn,
		op_orr, op_mov, op_bic, op_mvn
	} alu_op_e;

	// Shift types (ir[6:5])
	typedef enum logic [1:0] {
		sh_lsl,
		sh_lsr,
		sh_asr,
		sh_ror
	} shift_e;

	// Condition codes (ir[31:28])
	typedef enum logic [3:0] {
		cond_eq, cond_ne, cond_cs, cond_cc,
		cond_mi, cond_pl, cond_vs, cond_vc,
		cond_hi, cond_ls, cond_ge, cond_lt,
		cond_gt, cond_le, cond_al, cond_nv
	} cond_e;

endpackage

/* arm_decode.sv */
// Instruction family decoder
module arm_decode (
	input  logic [31:0]     ir,
	output arm_pkg::family_e family
);

	logic psr_xfer; // Opcode 10xx without S is the misc space
	logic word_pre; // Pre-indexed word access with no writeback

	assign psr_xfer = (ir[24:23] == 2'b10) && !ir[20];
	assign word_pre = ir[24] && !ir[22] && !ir[21];

	always_comb begin
		family = arm_pkg::fam_undef; // Default for anything unmatched
		case (ir[27:25])
			3'b001: begin
				if (!psr_xfer) begin
					family = arm_pkg::fam_dpi;
				end
			end
			3'b000: begin
				// Bit 4 picks the shift source, bit 7 set with bit 4 is multiply/halfword
				if (!psr_xfer) begin
					if (!ir[4]) begin
						family = arm_pkg::fam_dpis;
					end else if (!ir[7]) begin
						family = arm_pkg::fam_dprs;
					end
				end
			end
			3'b010: begin
				if (word_pre) begin
					family = arm_pkg::fam_lsio;
				end
			end
			3'b101: begin
				family = arm_pkg::fam_branch; // L bit handled by the controller
			end
			default: begin
				family = arm_pkg::fam_undef;
			end
		endcase
	end

endmodule

/* arm_shifter.sv */
// Addressing mode 1 shifter
module arm_shifter (
	input  logic [31:0]      ir,
	input  logic [31:0]      rm_data,
	input  logic [7:0]       rs_low,
	input  logic             carry_in,
	input  arm_pkg::family_e family,
	output logic [31:0]      operand,
	output logic             shifter_carry
);

	arm_pkg::shift_e sh_type;
	logic [7:0]      shift_amt; // Effective amount, 32 for the #0 encodings of LSR/ASR
	logic            rrx;       // ROR #0 in the immediate form
	logic            is_dp;
	logic [32:0]     asr_wide;  // Operand and carry shifted as one

	function automatic logic [31:0] ror32(input logic [31:0] x, input logic [4:0] n);
		logic [63:0] twice;
		twice = {x, x} >> n;
		return twice[31:0];
	endfunction

	assign sh_type = arm_pkg::shift_e'(ir[6:5]);
	assign is_dp = (family == arm_pkg::fam_dpi) || (family == arm_pkg::fam_dpis) ||
		(family == arm_pkg::fam_dprs);
	assign rrx = (family == arm_pkg::fam_dpis) && (sh_type == arm_pkg::sh_ror) &&
		(ir[11:7] == 5'd0);

	always_comb begin
		if (family == arm_pkg::fam_dprs) begin
			shift_amt = rs_low; // Full byte of Rs counts
		end else if ((ir[11:7] == 5'd0) && (sh_type != arm_pkg::sh_lsl)) begin
			shift_amt = 8'd32;
		end else begin
			shift_amt = {3'b000, ir[11:7]};
		end
	end

	assign asr_wide = $signed({rm_data, carry_in}) >>> shift_amt;

	always_comb begin
		operand = {20'h0, ir[11:0]}; // Load/store offset
		shifter_carry = carry_in;
		if (family == arm_pkg::fam_dpi) begin
			operand = ror32({24'h0, ir[7:0]}, {ir[11:8], 1'b0});
			if (ir[11:8] != 4'd0) begin
				shifter_carry = operand[31];
			end
		end else if (family == arm_pkg::fam_branch) begin
			operand = {{6{ir[23]}}, ir[23:0], 2'b00}; // Word offset to bytes
		end else if (is_dp) begin
			case (sh_type)
				arm_pkg::sh_lsl: {shifter_carry, operand} = {carry_in, rm_data} << shift_amt;
				arm_pkg::sh_lsr: {operand, shifter_carry} = {rm_data, carry_in} >> shift_amt;
				arm_pkg::sh_asr: {operand, shifter_carry} = asr_wide;
				default: begin
					if (rrx) begin
						operand = {carry_in, rm_data[31:1]};
						shifter_carry = rm_data[0];
					end else if (shift_amt != 8'd0) begin
						operand = ror32(rm_data, shift_amt[4:0]);
						shifter_carry = operand[31]; // Last bit rotated out
					end else begin
						operand = rm_data; // Rs of zero leaves Rm and C alone
					end
				end
			endcase
		end
	end

	// Data processing operand and carry fully known
	dp_known: assert final (!is_dp || !$isunknown({operand, shifter_carry}));

endmodule

/* arm_alu.sv */
// Data processing ALU
module arm_alu (
	input  arm_pkg::alu_op_e op,
	input  logic [31:0]      a,
	input  logic [31:0]      b,
	input  logic             carry_in,
	input  logic             shifter_carry,
	output logic [31:0]      result,
	output logic [3:0]       nzcv
);

	logic [31:0] x, y; // Adder inputs after swap and invert
	logic        cin;
	logic [32:0] sum;
	logic        arith;
	logic        c_flag;
	logic        v_flag;

	always_comb begin
		x = a;
		y = b;
		cin = 1'b0;
		arith = 1'b1;
		unique case (op)
			arm_pkg::op_sub, arm_pkg::op_cmp: begin y = ~b; cin = 1'b1; end
			arm_pkg::op_rsb: begin x = b; y = ~a; cin = 1'b1; end
			arm_pkg::op_add, arm_pkg::op_cmn: cin = 1'b0;
			arm_pkg::op_adc: cin = carry_in;
			arm_pkg::op_sbc: begin y = ~b; cin = carry_in; end
			arm_pkg::op_rsc: begin x = b; y = ~a; cin = carry_in; end
			default: arith = 1'b0; // Logical group
		endcase
	end

	assign sum = {1'b0, x} + {1'b0, y} + {32'h0, cin};

	always_comb begin
		unique case (op)
			arm_pkg::op_and, arm_pkg::op_tst: result = a & b;
			arm_pkg::op_eor, arm_pkg::op_teq: result = a ^ b;
			arm_pkg::op_orr: result = a | b;
			arm_pkg::op_mov: result = b;
			arm_pkg::op_bic: result = a & ~b;
			arm_pkg::op_mvn: result = ~b;
			default:         result = sum[31:0];
		endcase
	end

	// Subtract carry is NOT borrow, which the inverted operand already gives
	assign c_flag = arith ? sum[32] : shifter_carry;
	// Signed overflow when both inputs agree in sign and the sum does not
	// Logical ops report 0 here and the core keeps the old V
	assign v_flag = arith && (x[31] == y[31]) && (sum[31] != x[31]);

	assign nzcv = {result[31], result == 32'h0, c_flag, v_flag};

endmodule

/* arm_cond.sv */
// Flag register and condition check
module arm_cond (
	input  logic           clk,
	input  logic           rst,
	input  logic           flags_we,
	input  logic [3:0]     nzcv_next,
	input  arm_pkg::cond_e cond,
	output logic [3:0]     flags,
	output logic           cond_pass
);

	logic n, z, c, v;

	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= 4'h0;
		end else if (flags_we) begin
			flags <= nzcv_next; // S bit set and condition passed
		end
	end

	assign {n, z, c, v} = flags;

	always_comb begin
		unique case (cond)
			arm_pkg::cond_eq: cond_pass = z;
			arm_pkg::cond_ne: cond_pass = !z;
			arm_pkg::cond_cs: cond_pass = c;
			arm_pkg::cond_cc: cond_pass = !c;
			arm_pkg::cond_mi: cond_pass = n;
			arm_pkg::cond_pl: cond_pass = !n;
			arm_pkg::cond_vs: cond_pass = v;
			arm_pkg::cond_vc: cond_pass = !v;
			arm_pkg::cond_hi: cond_pass = c && !z;   // Unsigned higher
			arm_pkg::cond_ls: cond_pass = !c || z;
			arm_pkg::cond_ge: cond_pass = n == v;    // Signed compares
			arm_pkg::cond_lt: cond_pass = n != v;
			arm_pkg::cond_gt: cond_pass = !z && (n == v);
			arm_pkg::cond_le: cond_pass = z || (n != v);
			arm_pkg::cond_al: cond_pass = 1'b1;
			default:          cond_pass = 1'b0; // NV never runs
		endcase
	end

endmodule

/* arm_reg_bank.sv */
// Register file with program counter
module arm_reg_bank (
	input  logic        clk,
	input  logic        rst,
	input  logic [3:0]  rn_sel,
	input  logic [3:0]  rm_sel,
	input  logic [3:0]  rs_sel,
	input  logic [3:0]  wr_sel,
	input  logic [31:0] wr_data,
	input  logic        reg_we,
	input  logic        pc_inc,
	input  logic        pc_load,
	input  logic [31:0] pc_next,
	output logic [31:0] rn_data,
	output logic [31:0] rm_data,
	output logic [31:0] rs_data,
	output logic [31:0] pc
);

	logic [31:0] gpr [0:14]; // R0 to R14
	logic [31:0] pc_read;    // R15 as an operand

	// General registers, R15 never written here
	always_ff @(posedge clk) begin
		if (reg_we && (wr_sel != arm_pkg::reg_pc)) begin
			gpr[wr_sel] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= arm_pkg::start_address;
		end else if (pc_load) begin
			pc <= pc_next; // Branch or write to R15
		end else if (pc_inc) begin
			pc <= pc + 32'd4;
		end
	end

	// pc is already past the fetch, so one more word gives instruction address plus 8
	assign pc_read = pc + 32'd4;

	assign rn_data = (rn_sel == arm_pkg::reg_pc) ? pc_read : gpr[rn_sel];
	assign rm_data = (rm_sel == arm_pkg::reg_pc) ? pc_read : gpr[rm_sel];
	assign rs_data = (rs_sel == arm_pkg::reg_pc) ? pc_read : gpr[rs_sel];

	// A write to R15 must arrive as a pc load, never both at once
	no_pc_double_write: assert property (@(posedge clk) disable iff (rst)
		!(reg_we && pc_load && (wr_sel == arm_pkg::reg_pc)));

endmodule

/* arm_control.sv */
// Multicycle controller
module arm_control (
	input  logic             clk,
	input  logic             rst,
	input  arm_pkg::family_e family,
	input  logic             cond_pass,
	input  logic             load_bit,  // L bit, link bit for branches
	input  logic             s_bit,
	input  arm_pkg::alu_op_e op,
	output logic             ld_ir,
	output logic             ld_mar,
	output logic             mar_sel_pc,
	output logic             ld_mrdr,
	output logic             ld_mwdr,
	output logic             pc_inc,
	output logic             pc_load,
	output logic             reg_we,
	output logic             wr_sel_link,
	output logic             wr_sel_mem,
	output logic             flags_we,
	output logic             we,
	output logic             oe
);

	arm_pkg::state_e state, state_next;
	logic is_dp;
	logic test_op; // TST, TEQ, CMP, CMN write only flags

	assign is_dp = (family == arm_pkg::fam_dpi) || (family == arm_pkg::fam_dpis) ||
		(family == arm_pkg::fam_dprs);
	assign test_op = (op == arm_pkg::op_tst) || (op == arm_pkg::op_teq) ||
		(op == arm_pkg::op_cmp) || (op == arm_pkg::op_cmn);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= arm_pkg::st_fetch;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = arm_pkg::st_fetch;
		ld_ir = 1'b0;
		ld_mar = 1'b0;
		mar_sel_pc = 1'b0;
		ld_mrdr = 1'b0;
		ld_mwdr = 1'b0;
		pc_inc = 1'b0;
		pc_load = 1'b0;
		reg_we = 1'b0;
		wr_sel_link = 1'b0;
		wr_sel_mem = 1'b0;
		flags_we = 1'b0;
		we = 1'b0;
		oe = 1'b0;
		unique case (state)
			arm_pkg::st_fetch: begin
				mar_sel_pc = 1'b1; // Address straight from pc
				oe = 1'b1;
				ld_ir = 1'b1;
				pc_inc = 1'b1;
				state_next = arm_pkg::st_decode;
			end
			arm_pkg::st_decode: begin
				// Failed load/store falls into exec as a no-op
				if ((family == arm_pkg::fam_lsio) && cond_pass) begin
					state_next = arm_pkg::st_mem_addr;
				end else begin
					state_next = arm_pkg::st_exec;
				end
			end
			arm_pkg::st_exec: begin
				if (cond_pass && is_dp) begin
					reg_we = !test_op;
					flags_we = s_bit;
				end
				if (cond_pass && (family == arm_pkg::fam_branch)) begin
					pc_load = 1'b1;
					reg_we = load_bit; // BL writes R14
					wr_sel_link = load_bit;
				end
			end
			arm_pkg::st_mem_addr: begin
				ld_mar = 1'b1;  // Rn plus or minus offset
				ld_mwdr = 1'b1; // Store data from Rd
				state_next = load_bit ? arm_pkg::st_mem_read : arm_pkg::st_mem_write;
			end
			arm_pkg::st_mem_read: begin
				oe = 1'b1;
				ld_mrdr = 1'b1;
				state_next = arm_pkg::st_writeback;
			end
			arm_pkg::st_writeback: begin
				reg_we = 1'b1;
				wr_sel_mem = 1'b1;
			end
			arm_pkg::st_mem_write: we = 1'b1;
			default: state_next = arm_pkg::st_fetch;
		endcase
	end

	no_bus_clash: assert property (@(posedge clk) disable iff (rst) !(we && oe));

	fetch_then_decode: assert property (@(posedge clk) disable iff (rst)
		(state == arm_pkg::st_fetch) |=> (state == arm_pkg::st_decode));

endmodule

/* arm_core.sv */
// ARMv4 subset core
module arm_core (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] rdata,
	output logic [31:0] address, // Byte address, word aligned
	output logic [31:0] wdata,
	output logic        we,
	output logic        oe
);

	logic [31:0] ir, mar, mrdr, mwdr; // Top level registers

	arm_pkg::family_e family;
	arm_pkg::alu_op_e alu_op;
	logic ld_ir, ld_mar, mar_sel_pc, ld_mrdr, ld_mwdr;
	logic pc_inc, pc_load, reg_we, wr_sel_link, wr_sel_mem, flags_we;
	logic cond_pass, load_bit, logical_op;
	logic rb_reg_we, rb_pc_load;
	logic [3:0] rm_sel, wr_sel, flags, alu_nzcv, nzcv_next;
	logic [31:0] rn_data, rm_data, rs_data, pc;
	logic [31:0] operand, alu_a, alu_result, wr_data, pc_next;
	logic shifter_carry;

	always_ff @(posedge clk) begin
		if (ld_ir) ir <= rdata;
		if (ld_mar) mar <= alu_result;
		if (ld_mrdr) mrdr <= rdata;
		if (ld_mwdr) mwdr <= rm_data;
	end

	assign address = mar_sel_pc ? pc : {mar[31:2], 2'b00};
	assign wdata = mwdr;

	// Load/store reuses the Rm port for the store data in Rd
	assign rm_sel = (family == arm_pkg::fam_lsio) ? ir[15:12] : ir[3:0];
	assign wr_sel = wr_sel_link ? arm_pkg::reg_lr : ir[15:12];
	assign load_bit = (family == arm_pkg::fam_branch) ? ir[24] : ir[20];

	always_comb begin
		if (family == arm_pkg::fam_lsio) begin
			alu_op = ir[23] ? arm_pkg::op_add : arm_pkg::op_sub; // U bit
		end else if (family == arm_pkg::fam_branch) begin
			alu_op = arm_pkg::op_add;
		end else begin
			alu_op = arm_pkg::alu_op_e'(ir[24:21]);
		end
	end

	assign alu_a = (family == arm_pkg::fam_branch) ? pc + 32'd4 : rn_data; // Branch base pc+8
	assign wr_data = wr_sel_mem ? mrdr : (wr_sel_link ? pc : alu_result); // Link is pc+4
	assign pc_next = wr_sel_mem ? mrdr : alu_result;

	// Writes to R15 become pc loads
	assign rb_reg_we = reg_we && (wr_sel != arm_pkg::reg_pc);
	assign rb_pc_load = pc_load || (reg_we && (wr_sel == arm_pkg::reg_pc));

	// Logical opcodes keep V
	assign logical_op = !(alu_op inside {arm_pkg::op_sub, arm_pkg::op_rsb, arm_pkg::op_add,
		arm_pkg::op_adc, arm_pkg::op_sbc, arm_pkg::op_rsc, arm_pkg::op_cmp, arm_pkg::op_cmn});
	assign nzcv_next = {alu_nzcv[3:1], logical_op ? flags[0] : alu_nzcv[0]};

	arm_decode i_decode (.ir(ir), .family(family));

	arm_shifter i_shifter (
		.ir(ir), .rm_data(rm_data), .rs_low(rs_data[7:0]), .carry_in(flags[1]),
		.family(family), .operand(operand), .shifter_carry(shifter_carry)
	);

	arm_alu i_alu (
		.op(alu_op), .a(alu_a), .b(operand), .carry_in(flags[1]),
		.shifter_carry(shifter_carry), .result(alu_result), .nzcv(alu_nzcv)
	);

	arm_cond i_cond (
		.clk(clk), .rst(rst), .flags_we(flags_we), .nzcv_next(nzcv_next),
		.cond(arm_pkg::cond_e'(ir[31:28])), .flags(flags), .cond_pass(cond_pass)
	);

	arm_reg_bank i_reg_bank (
		.clk(clk), .rst(rst), .rn_sel(ir[19:16]), .rm_sel(rm_sel), .rs_sel(ir[11:8]),
		.wr_sel(wr_sel), .wr_data(wr_data), .reg_we(rb_reg_we), .pc_inc(pc_inc),
		.pc_load(rb_pc_load), .pc_next(pc_next), .rn_data(rn_data), .rm_data(rm_data),
		.rs_data(rs_data), .pc(pc)
	);

	arm_control i_control (
		.clk(clk), .rst(rst), .family(family), .cond_pass(cond_pass),
		.load_bit(load_bit), .s_bit(ir[20]), .op(arm_pkg::alu_op_e'(ir[24:21])),
		.ld_ir(ld_ir), .ld_mar(ld_mar), .mar_sel_pc(mar_sel_pc), .ld_mrdr(ld_mrdr),
		.ld_mwdr(ld_mwdr), .pc_inc(pc_inc), .pc_load(pc_load), .reg_we(reg_we),
		.wr_sel_link(wr_sel_link), .wr_sel_mem(wr_sel_mem), .flags_we(flags_we),
		.we(we), .oe(oe)
	);

endmodule

/* tb_arm_core.sv */
// ARM core testbench
module tb_arm_core;

	localparam int max_exp = 64;              // Room for expected stores
	localparam logic [31:0] reset_pc = 32'h0; // First fetch address after reset

	logic        clk;
	logic        rst;
	logic [31:0] rdata;
	logic [31:0] address;
	logic [31:0] wdata;
	logic        we;
	logic        oe;

	logic [31:0]     mem [0:255];         // 1 KB of word memory
	logic [8*16-1:0] exp_name [0:max_exp-1];
	logic [31:0]     exp_addr [0:max_exp-1];
	logic [31:0]     exp_data [0:max_exp-1];
	int n_words;  // M lines read
	int n_exp;    // E lines read
	int exp_idx;  // Next expected store
	int cycles;
	int limit;
	int errors;
	int checks;

	arm_core i_dut (
		.clk(clk), .rst(rst), .rdata(rdata), .address(address),
		.wdata(wdata), .we(we), .oe(oe)
	);

	// Combinational read, same cycle as the address
	assign rdata = mem[address[9:2]];

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(input logic [8*16-1:0] test, input logic [8*8-1:0] what,
		input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERROR %0s %0s: expected %h, actual %h", test, what, expected, actual);
		end
	endtask

	task automatic load_tests();
		int fd;
		int r;
		int i;
		logic [7:0]       tag;
		logic [31:0]      a;
		logic [31:0]      d;
		logic [8*16-1:0]  nm;
		logic [8*120-1:0] rest;
		for (i = 0; i < 256; i++) begin
			mem[i] = {24'he7f000, i[7:0]}; // Undefined encoding, runs as a no-op
		end
		n_words = 0;
		n_exp = 0;
		fd = $fopen("arm_tests.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open arm_tests.txt, no program was loaded");
		end else begin
			while ($fscanf(fd, " %c", tag) == 1) begin
				if (tag == "M") begin
					r = $fscanf(fd, "%h %h", a, d); // Word index and word
					mem[a[7:0]] = d;
					n_words++;
				end else if (tag == "E" && n_exp < max_exp) begin
					r = $fscanf(fd, "%s %h %h", nm, a, d);
					exp_name[n_exp] = nm;
					exp_addr[n_exp] = a;
					exp_data[n_exp] = d;
					n_exp++;
				end
				r = $fgets(rest, fd); // Trailing comment or header text
			end
			$fclose(fd);
		end
	endtask

	// Store monitor and memory write port
	always @(posedge clk) begin
		cycles++;
		if (!rst && we) begin
			mem[address[9:2]] <= wdata;
			if (exp_idx < n_exp) begin
				check_value(exp_name[exp_idx], "address", exp_addr[exp_idx], address);
				check_value(exp_name[exp_idx], "data", exp_data[exp_idx], wdata);
				exp_idx++;
			end else begin
				errors++;
				$display("Unexpected write of %h to address %h after the last expected store",
					wdata, address);
			end
		end
	end

	initial begin
		rst = 1'b1;
		errors = 0;
		checks = 0;
		exp_idx = 0;
		cycles = 0;
		load_tests();
		limit = 5 * n_words + 50; // Worst case five cycles per word
		repeat (5) @(posedge clk);
		#1 rst = 1'b0;
		#2;
		// First cycle out of reset is a fetch from the reset address
		check_value("reset", "oe", 32'd1, {31'd0, oe});
		check_value("reset", "address", reset_pc, address);
		check_value("reset", "we", 32'd0, {31'd0, we});
		while (exp_idx < n_exp && cycles < limit) begin
			@(posedge clk);
			#2;
		end
		if (exp_idx < n_exp) begin
			errors++;
			$display("Timeout after %0d cycles, %0d of %0d expected stores missing",
				cycles, n_exp - exp_idx, n_exp);
		end else begin
			repeat (10) @(posedge clk); // Core spins on B . here, stray stores show up
		end
		#2;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* arm_tests.txt */
# M <word index> <instruction word>    program and data words, hex
# E <test name> <store address> <store data>    expected stores in program order, hex
M 00 e3a0cc03 # mov r12, #0x300      store base
M 01 e3a004ff # mov r0, #0xff000000
M 02 e58c0000 # str r0, [r12]
M 03 e2401001 # sub r1, r0, #1
M 04 e58c1004 # str r1, [r12, #4]
M 05 e2612000 # rsb r2, r1, #0
M 06 e58c2008 # str r2, [r12, #8]
M 07 e3e03055 # mvn r3, #0x55
M 08 e58c300c # str r3, [r12, #12]
M 09 e3c340f0 # bic r4, r3, #0xf0
M 0a e58c4010 # str r4, [r12, #16]
M 0b e0905000 # adds r5, r0, r0      sets N and C
M 0c e2a26010 # adc r6, r2, #0x10
M 0d e58c6014 # str r6, [r12, #20]
M 0e e2227c0f # eor r7, r2, #0xf00
M 0f e58c7018 # str r7, [r12, #24]
M 10 e3a08186 # mov r8, #0x80000021
M 11 e1a09208 # mov r9, r8, lsl #4
M 12 e58c901c # str r9, [r12, #28]
M 13 e1a09048 # mov r9, r8, asr #32
M 14 e58c9020 # str r9, [r12, #32]
M 15 e1a09428 # mov r9, r8, lsr #8
M 16 e58c9024 # str r9, [r12, #36]
M 17 e1a09268 # mov r9, r8, ror #4
M 18 e58c9028 # str r9, [r12, #40]
M 19 e1a09068 # mov r9, r8, rrx      C is 1
M 1a e58c902c # str r9, [r12, #44]
M 1b e3a0a004 # mov r10, #4
M 1c e1a09a58 # mov r9, r8, asr r10
M 1d e58c9030 # str r9, [r12, #48]
M 1e e3a0a000 # mov r10, #0
M 1f e1a09a78 # mov r9, r8, ror r10
M 20 e58c9034 # str r9, [r12, #52]
M 21 e3a0a020 # mov r10, #32
M 22 e1a09a38 # mov r9, r8, lsr r10
M 23 e58c9038 # str r9, [r12, #56]
M 24 e35a0020 # cmp r10, #32         Z and C set
M 25 03a0b011 # moveq r11, #0x11
M 26 13a0b022 # movne r11, #0x22     fails
M 27 e58cb03c # str r11, [r12, #60]
M 28 e3180001 # tst r8, #1           Z clear
M 29 13a0b033 # movne r11, #0x33
M 2a 03a0b044 # moveq r11, #0x44     fails
M 2b e58cb040 # str r11, [r12, #64]
M 2c e3e0b102 # mvn r11, #0x80000000
M 2d e29bb001 # adds r11, r11, #1    N and V set, C clear
M 2e 63a03055 # movvs r3, #0x55
M 2f 23a03066 # movcs r3, #0x66      fails
M 30 e58c3044 # str r3, [r12, #68]
M 31 e50c6008 # str r6, [r12, #-8]
M 32 e51c5008 # ldr r5, [r12, #-8]
M 33 e1a0d005 # mov r13, r5
M 34 e58cd048 # str r13, [r12, #72]
M 35 e59c50f0 # ldr r5, [r12, #0xf0]
M 36 e58c504c # str r5, [r12, #76]
M 37 ea000000 # b 0xe4
M 38 e58c0050 # str r0, [r12, #80]   skipped
M 39 eb000000 # bl 0xec
M 3a e58c0050 # str r0, [r12, #80]   skipped
M 3b e58ce050 # str r14, [r12, #80]
M 3c e1a0100f # mov r1, pc
M 3d e58c1054 # str r1, [r12, #84]
M 3e 0a000000 # beq 0x100            not taken
M 3f e58c3058 # str r3, [r12, #88]
M 40 258c305c # strcs r3, [r12, #92] fails
M 41 eafffffe # b .
M fc 5a5ac3c3 # data word at 0x3f0
E mov_rot_imm   00000300 ff000000
E sub_imm       00000304 feffffff
E rsb_imm       00000308 01000001
E mvn_imm       0000030c ffffffaa
E bic_imm       00000310 ffffff0a
E adc_imm       00000314 01000012
E eor_rot_imm   00000318 01000f01
E lsl_imm       0000031c 00000210
E asr_imm_32    00000320 ffffffff
E lsr_imm       00000324 00800000
E ror_imm       00000328 18000002
E rrx           0000032c c0000010
E asr_reg       00000330 f8000002
E ror_reg_0     00000334 80000021
E lsr_reg_32    00000338 00000000
E cmp_eq_cond   0000033c 00000011
E tst_ne_cond   00000340 00000033
E adds_vs_cond  00000344 00000055
E str_down      000002f8 01000012
E ldr_copy      00000348 01000012
E ldr_data      0000034c 5a5ac3c3
E bl_link       00000350 000000e8
E pc_read       00000354 000000f8
E beq_not_taken 00000358 00000055

/* tb.f */
arm_pkg.sv
arm_decode.sv
arm_shifter.sv
arm_alu.sv
arm_cond.sv
arm_reg_bank.sv
arm_control.sv
arm_core.sv
tb_arm_core.sv

/* Bender.yml */
package:
  name: arm_core

sources:
  - arm_pkg.sv
  - arm_decode.sv
  - arm_shifter.sv
  - arm_alu.sv
  - arm_cond.sv
  - arm_reg_bank.sv
  - arm_control.sv
  - arm_core.sv
  - target: simulation
    files:
      - tb_arm_core.sv
